// ==== hdl/uart_pkg.sv ====
package uart_pkg;

    // Bit timing, kept short for simulation
    localparam int clocks_per_bit    = 16;
    localparam int clock_count_width = $clog2(clocks_per_bit);

    // Counter value at mid-bit and at the last cycle of a bit period
    localparam logic [clock_count_width-1:0] sample_point =
        clock_count_width'(clocks_per_bit / 2 - 1);
    localparam logic [clock_count_width-1:0] bit_end_count =
        clock_count_width'(clocks_per_bit - 1);

    // Receiver FSM codes
    localparam logic [1:0] rx_idle = 2'b00;
    localparam logic [1:0] rx_work = 2'b01;
    localparam logic [1:0] rx_done = 2'b11;

    // Echo queue, depth must be a power of two
    localparam int queue_depth      = 4;
    localparam int queue_addr_width = $clog2(queue_depth);

    // Case-mode codes carried in a command byte
    localparam logic [1:0] mode_pass  = 2'd0;
    localparam logic [1:0] mode_upper = 2'd1;
    localparam logic [1:0] mode_lower = 2'd2;

    // One received byte, read as a character or as a command
    // The top bit tells the two apart
    typedef union packed {
        struct packed {
            logic       is_command;
            logic [6:0] code;
        } character;
        struct packed {
            logic       is_command;
            logic [4:0] reserved;
            logic [1:0] mode;
        } command;
    } uart_byte_u;

endpackage

// ==== hdl/uart_receiver.sv ====
`timescale 1ns/1ps

module uart_receiver (
    input  logic       clk,
    input  logic       rst,

    // Received byte towards the sink
    output logic [7:0] data_out,
    output logic       data_out_valid,
    input  logic       data_out_ready,

    // Serial line
    input  logic       serial_in
);

    logic [1:0]                             state;
    logic [uart_pkg::clock_count_width-1:0] clock_count;
    logic [3:0]                             bit_count;
    logic [9:0]                             rx_shift;
    logic                                   is_symbol_edge;
    logic                                   is_sample_time;
    logic                                   data_out_fire;

    assign is_symbol_edge = (clock_count == uart_pkg::bit_end_count);
    assign is_sample_time = (clock_count == uart_pkg::sample_point);
    assign data_out_fire  = data_out_valid && data_out_ready;

    // Idle, receiving a frame, or holding a byte for the sink
    // The frame is closed at the stop-bit sample, so the FSM is back in
    // idle before a back-to-back start bit can begin
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= uart_pkg::rx_idle;
        end else begin
            case (state)
                uart_pkg::rx_idle: begin
                    if (!serial_in) begin
                        state <= uart_pkg::rx_work;
                    end
                end
                uart_pkg::rx_work: begin
                    if (bit_count == 4'd9 && is_sample_time) begin
                        state <= uart_pkg::rx_done;
                    end
                end
                uart_pkg::rx_done: begin
                    // New start bits are ignored until the byte is taken
                    if (data_out_fire) begin
                        state <= uart_pkg::rx_idle;
                    end
                end
                default: begin
                    state <= uart_pkg::rx_idle;
                end
            endcase
        end
    end

    // Position inside the current bit period
    always_ff @(posedge clk) begin
        if (rst || state != uart_pkg::rx_work) begin
            clock_count <= '0;
        end else if (is_symbol_edge) begin
            clock_count <= '0;
        end else begin
            clock_count <= clock_count + 1'b1;
        end
    end

    // Index of the bit being received, start bit is 0
    always_ff @(posedge clk) begin
        if (rst || state == uart_pkg::rx_idle) begin
            bit_count <= 4'd0;
        end else if (state == uart_pkg::rx_work && is_symbol_edge) begin
            bit_count <= bit_count + 4'd1;
        end
    end

    // Bits land LSB first at their own index
    always_ff @(posedge clk) begin
        if (state == uart_pkg::rx_work && is_sample_time) begin
            rx_shift[bit_count] <= serial_in;
        end
    end

    assign data_out_valid = (state == uart_pkg::rx_done);
    assign data_out       = rx_shift[8:1];

    // A held byte must not change before the sink takes it
    a_data_held: assert property (
        @(posedge clk) disable iff (rst)
        (data_out_valid && !data_out_ready) |=> (data_out_valid && $stable(data_out))
    ) else $error("uart_receiver: data_out changed while waiting for ready");

endmodule

// ==== hdl/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter (
    input  logic       clk,
    input  logic       rst,

    // Byte from the source
    input  logic [7:0] data_in,
    input  logic       data_in_valid,
    output logic       data_in_ready,

    // Serial line
    output logic       serial_out
);

    logic                                   busy;
    logic [uart_pkg::clock_count_width-1:0] clock_count;
    logic [3:0]                             bit_count;
    logic [9:0]                             tx_shift;
    logic                                   data_in_fire;
    logic                                   is_symbol_edge;
    logic                                   is_last_bit;

    assign data_in_ready  = !busy;
    assign data_in_fire   = data_in_valid && data_in_ready;
    assign is_symbol_edge = (clock_count == uart_pkg::bit_end_count);
    assign is_last_bit    = (bit_count == 4'd9);

    // Busy from the load until the end of the stop bit
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (data_in_fire) begin
            busy <= 1'b1;
        end else if (busy && is_symbol_edge && is_last_bit) begin
            busy <= 1'b0;
        end
    end

    // Cycle within the bit now on the line
    always_ff @(posedge clk) begin
        if (rst || !busy) begin
            clock_count <= '0;
        end else if (is_symbol_edge) begin
            clock_count <= '0;
        end else begin
            clock_count <= clock_count + 1'b1;
        end
    end

    // Bits already sent in this frame
    always_ff @(posedge clk) begin
        if (rst || !busy) begin
            bit_count <= 4'd0;
        end else if (is_symbol_edge) begin
            bit_count <= bit_count + 4'd1;
        end
    end

    // Frame is stop, data MSB..LSB, start; bit 0 drives the line
    // Ones are shifted in behind, so the line rests high
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_shift <= '1;
        end else if (data_in_fire) begin
            tx_shift <= {1'b1, data_in, 1'b0};
        end else if (busy && is_symbol_edge) begin
            tx_shift <= {1'b1, tx_shift[9:1]};
        end
    end

    assign serial_out = tx_shift[0];

    // Line must rest at the mark level between frames
    a_idle_high: assert property (
        @(posedge clk) disable iff (rst)
        !busy |-> serial_out
    ) else $error("uart_transmitter: serial_out low while idle");

endmodule

// ==== hdl/echo_control.sv ====
`timescale 1ns/1ps

module echo_control (
    input  logic       clk,
    input  logic       rst,

    // Bytes from the receiver
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       rx_ready,

    // Echo bytes towards the transmitter
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);

    uart_pkg::uart_byte_u                  rx_byte;
    logic [1:0]                            mode;
    logic [7:0]                            queue_mem [uart_pkg::queue_depth];
    logic [uart_pkg::queue_addr_width-1:0] wr_ptr;
    logic [uart_pkg::queue_addr_width-1:0] rd_ptr;
    logic [uart_pkg::queue_addr_width:0]   count;
    logic                                  full;
    logic                                  empty;
    logic                                  is_command;
    logic                                  rx_fire;
    logic                                  tx_fire;
    logic                                  wr_en;
    logic [6:0]                            echo_code;

    // Only letters change case
    function automatic logic [6:0] apply_case(input logic [1:0] sel, input logic [6:0] code);
        logic is_lower;
        logic is_upper;
        is_lower   = (code >= 7'h61) && (code <= 7'h7a);
        is_upper   = (code >= 7'h41) && (code <= 7'h5a);
        apply_case = code;
        if (sel == uart_pkg::mode_upper && is_lower) begin
            apply_case = code & 7'h5f;
        end else if (sel == uart_pkg::mode_lower && is_upper) begin
            apply_case = code | 7'h20;
        end
    endfunction

    assign rx_byte    = rx_data;
    assign is_command = rx_byte.command.is_command;

    assign full  = (count == (uart_pkg::queue_addr_width + 1)'(uart_pkg::queue_depth));
    assign empty = (count == '0);

    // Commands never need queue space
    assign rx_ready  = !full || is_command;
    assign rx_fire   = rx_valid && rx_ready;
    assign wr_en     = rx_fire && !is_command;
    assign echo_code = apply_case(mode, rx_byte.character.code);

    assign tx_valid = !empty;
    assign tx_data  = queue_mem[rd_ptr];
    assign tx_fire  = tx_valid && tx_ready;

    // Codes outside the three modes leave the mode as it is
    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= uart_pkg::mode_pass;
        end else if (rx_fire && is_command) begin
            case (rx_byte.command.mode)
                uart_pkg::mode_pass,
                uart_pkg::mode_upper,
                uart_pkg::mode_lower: begin
                    mode <= rx_byte.command.mode;
                end
                default: begin
                    mode <= mode;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            queue_mem[wr_ptr] <= {1'b0, echo_code};
        end
    end

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (tx_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, tx_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Pointers meet only when the queue is empty or full
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> ((wr_ptr != rd_ptr) || empty)
    ) else $error("echo_control: character written into a full queue");

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (rst)
        tx_fire |-> ((wr_ptr != rd_ptr) || full)
    ) else $error("echo_control: transmitter read from an empty queue");

endmodule

// ==== hdl/uart_echo_top.sv ====
`timescale 1ns/1ps

module uart_echo_top (
    input  logic clk,
    input  logic rst,
    input  logic serial_in,
    output logic serial_out
);

    // Receiver to controller
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_ready;

    // Controller to transmitter
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;

    uart_receiver u_receiver (
        .clk            (clk),
        .rst            (rst),
        .data_out       (rx_data),
        .data_out_valid (rx_valid),
        .data_out_ready (rx_ready),
        .serial_in      (serial_in)
    );

    // Mode decoding, case transform and echo queue
    echo_control u_echo_control (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    uart_transmitter u_transmitter (
        .clk           (clk),
        .rst           (rst),
        .data_in       (tx_data),
        .data_in_valid (tx_valid),
        .data_in_ready (tx_ready),
        .serial_out    (serial_out)
    );

endmodule

// ==== testbench/uart_tb_tasks.svh ====
// One serial frame on serial_in, LSB first, single stop bit
task automatic send_frame(input logic [7:0] data);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, data, 1'b0};
    for (i = 0; i < 10; i++) begin
        @(posedge clk);
        #drive_delay;
        serial_in = frame[i];
        repeat (uart_pkg::clocks_per_bit - 1) @(posedge clk);
    end
endtask

// Reference echo rules: commands set the mode, characters are queued
task automatic model_accept(input uart_pkg::uart_byte_u b);
    uart_pkg::uart_byte_u echo;
    logic [6:0]           code;
    if (b.command.is_command) begin
        if (b.command.mode == uart_pkg::mode_pass ||
            b.command.mode == uart_pkg::mode_upper ||
            b.command.mode == uart_pkg::mode_lower) begin
            model_mode = b.command.mode;
        end
    end else begin
        code = b.character.code;
        echo = b;
        // ASCII letters sit 32 codes apart between the two cases
        if (model_mode == uart_pkg::mode_upper && code >= 7'h61 && code <= 7'h7a) begin
            echo.character.code = code - 7'd32;
        end else if (model_mode == uart_pkg::mode_lower && code >= 7'h41 && code <= 7'h5a) begin
            echo.character.code = code + 7'd32;
        end
        expected_q.push_back(echo);
    end
endtask

task automatic send_byte(input uart_pkg::uart_byte_u b);
    model_accept(b);
    send_frame(b);
endtask

task automatic check_byte(input string name, input uart_pkg::uart_byte_u actual,
                          input uart_pkg::uart_byte_u expected);
    if (actual !== expected) begin
        $display("MISMATCH at %0t: %s got 0x%02h expected 0x%02h",
                 $time, name, actual, expected);
        mismatch_count++;
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("MISMATCH at %0t: %s got %b expected %b", $time, name, actual, expected);
        mismatch_count++;
    end
endtask

// ==== testbench/uart_echo_tb.sv ====
`timescale 1ns/1ps

module uart_echo_tb;

    localparam int clock_half_period = 50;
    localparam int drive_delay       = 10;
    localparam int reset_cycles      = 3;
    localparam int idle_bit_periods  = 20;

    // Bytes per test phase with the commands counted on their own
    localparam int pass_chars    = 16;
    localparam int upper_chars   = 16;
    localparam int lower_chars   = 12;
    localparam int restore_chars = 8;
    localparam int mix_bytes     = 48;
    localparam int command_bytes = 3;
    localparam int total_bytes   = pass_chars + upper_chars + lower_chars
                                   + restore_chars + mix_bytes + command_bytes;

    localparam int timeout_cycles = total_bytes * 12 * uart_pkg::clocks_per_bit * 2 + 1000;
    localparam int drain_limit    = (uart_pkg::queue_depth + 3) * 10 * uart_pkg::clocks_per_bit;

    logic                 clk;
    logic                 rst;
    logic                 serial_in;
    logic                 serial_out;

    integer               seed;
    int                   mismatch_count    = 0;
    int                   frame_error_count = 0;
    int                   cycle_count       = 0;
    logic [1:0]           model_mode;
    uart_pkg::uart_byte_u expected_q[$];

    `include "uart_tb_tasks.svh"

    uart_echo_top UUT (
        .clk        (clk),
        .rst        (rst),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #clock_half_period clk = ~clk;
        end
    end

    // Random character that may be biased towards letters of either case
    task automatic make_char(input bit favour_letters, output uart_pkg::uart_byte_u b);
        int unsigned pick;
        int unsigned kind;
        pick = $unsigned($random(seed));
        kind = favour_letters ? pick % 3 : 0;
        b.character.is_command = 1'b0;
        case (kind)
            1: b.character.code = 7'h61 + 7'((pick / 3) % 26);
            2: b.character.code = 7'h41 + 7'((pick / 3) % 26);
            default: b.character.code = 7'(pick / 3);
        endcase
    endtask

    // Reserved bits are random and must not matter to the DUT
    task automatic send_command(input logic [1:0] mode);
        uart_pkg::uart_byte_u b;
        b.command.is_command = 1'b1;
        b.command.reserved   = 5'($random(seed));
        b.command.mode       = mode;
        send_byte(b);
    endtask

    task automatic send_chars(input int n, input bit favour_letters);
        uart_pkg::uart_byte_u b;
        int                   k;
        for (k = 0; k < n; k++) begin
            make_char(favour_letters, b);
            send_byte(b);
        end
    endtask

    // Roughly one command in four with frames back to back
    task automatic send_mix(input int n);
        uart_pkg::uart_byte_u b;
        int unsigned          pick;
        int                   k;
        for (k = 0; k < n; k++) begin
            pick = $unsigned($random(seed));
            if (pick % 4 == 0) begin
                send_command(2'((pick / 4) % 3));
            end else begin
                make_char(1'b1, b);
                send_byte(b);
            end
        end
    endtask

    task automatic wait_for_echoes();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("%0d expected echo frames never appeared on serial_out by %0t",
                     expected_q.size(), $time);
            frame_error_count += expected_q.size();
            expected_q.delete();
        end
    endtask

    // Scoreboard
    task automatic score_echo(input uart_pkg::uart_byte_u got);
        if (expected_q.size() == 0) begin
            $display("Unexpected frame 0x%02h on serial_out at %0t", got, $time);
            frame_error_count++;
        end else begin
            check_byte("echo byte", got, expected_q.pop_front());
        end
    endtask

    // Output decoder aligned on the start edge and sampled near mid-bit
    initial begin : output_monitor
        logic [7:0] bits;
        int         i;
        @(negedge rst);
        forever begin
            @(negedge serial_out);
            repeat (uart_pkg::clocks_per_bit / 2) @(negedge clk);
            check_bit("serial_out start bit", serial_out, 1'b0);
            for (i = 0; i < 8; i++) begin
                repeat (uart_pkg::clocks_per_bit) @(negedge clk);
                bits[i] = serial_out;
            end
            repeat (uart_pkg::clocks_per_bit) @(negedge clk);
            if (serial_out !== 1'b1) begin
                $display("Frame carrying 0x%02h has no stop bit at %0t", bits, $time);
                frame_error_count++;
            end
            score_echo(bits);
        end
    end

    initial begin : watchdog
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run did not finish within %0d cycles", timeout_cycles);
        $display("Errors: %0d mismatches, %0d frame errors",
                 mismatch_count, frame_error_count);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        seed       = 25939;
        model_mode = uart_pkg::mode_pass;
        rst        = 1'b1;
        serial_in  = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst = 1'b0;

        // Line must stay quiet with nothing received
        repeat (idle_bit_periods * uart_pkg::clocks_per_bit) begin
            @(negedge clk);
            check_bit("serial_out", serial_out, 1'b1);
        end

        send_chars(pass_chars, 1'b0);
        wait_for_echoes();

        send_command(uart_pkg::mode_upper);
        send_chars(upper_chars, 1'b1);
        wait_for_echoes();

        send_command(uart_pkg::mode_lower);
        send_chars(lower_chars, 1'b1);
        send_command(uart_pkg::mode_pass);
        send_chars(restore_chars, 1'b1);
        wait_for_echoes();

        send_mix(mix_bytes);
        wait_for_echoes();

        // Room for a stray frame to start and be decoded in full
        repeat (3 * 10 * uart_pkg::clocks_per_bit) @(posedge clk);

        $display("Errors: %0d mismatches, %0d frame errors",
                 mismatch_count, frame_error_count);
        if (mismatch_count == 0 && frame_error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+testbench
hdl/uart_pkg.sv
hdl/uart_receiver.sv
hdl/uart_transmitter.sv
hdl/echo_control.sv
hdl/uart_echo_top.sv
testbench/uart_echo_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = uart_echo_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL (see $(LOG))"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
